// ==== mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    localparam int INST_W  = 32;
    localparam int OP_W    = 6;
    localparam int FUNCT_W = 6;
    localparam int REG_W   = 5;
    localparam int IMM_W   = 16;
    localparam int ADDR_W  = 26;

    // lsb position of each field in the word
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_LSB   = 0;
    localparam int ADDR_LSB  = 0;

    // major opcodes in bits 31:26
    typedef enum logic [OP_W-1:0] {
        OP_SPECIAL = 6'h00,  // real op sits in funct for R-type
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // funct codes under OP_SPECIAL
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03,
        FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22,
        FN_SUBU = 6'h23, FN_AND  = 6'h24, FN_OR   = 6'h25,
        FN_XOR  = 6'h26, FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    // one code per supported instruction, grouped by class
    typedef enum logic [7:0] {
        INST_INVALID = 8'h00,
        // register class
        INST_ADD  = 8'h01, INST_ADDU = 8'h02, INST_SUB  = 8'h03,
        INST_SUBU = 8'h04, INST_AND  = 8'h05, INST_OR   = 8'h06,
        INST_XOR  = 8'h07, INST_NOR  = 8'h08, INST_SLT  = 8'h09,
        INST_SLTU = 8'h0a, INST_SLL  = 8'h0b, INST_SRL  = 8'h0c,
        INST_SRA  = 8'h0d, INST_SLLV = 8'h0e, INST_SRLV = 8'h0f,
        INST_SRAV = 8'h10, INST_JR   = 8'h11,
        // immediate class
        INST_ADDI  = 8'h20, INST_ADDIU = 8'h21, INST_ANDI = 8'h22,
        INST_ORI   = 8'h23, INST_XORI  = 8'h24, INST_LUI  = 8'h25,
        INST_SLTI  = 8'h26, INST_SLTIU = 8'h27, INST_BEQ  = 8'h28,
        INST_BNE   = 8'h29, INST_LW    = 8'h2a, INST_SW   = 8'h2b,
        // jump class
        INST_J   = 8'h40,
        INST_JAL = 8'h41
    } inst_e;

    typedef enum logic [1:0] {
        INST_TYPE_INVALID = 2'd0,
        INST_TYPE_R       = 2'd1,
        INST_TYPE_I       = 2'd2,
        INST_TYPE_J       = 2'd3
    } inst_type_e;

endpackage

`default_nettype wire

// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    // register class result
    typedef struct packed {
        mips_isa_pkg::inst_e               inst;
        logic [mips_isa_pkg::REG_W-1:0]    reg_s;
        logic [mips_isa_pkg::REG_W-1:0]    reg_t;
        logic [mips_isa_pkg::REG_W-1:0]    reg_d;
        logic [mips_isa_pkg::REG_W-1:0]    shift;  // SLL SRL SRA only
    } r_fields_t;

    // immediate class result
    typedef struct packed {
        mips_isa_pkg::inst_e               inst;
        logic [mips_isa_pkg::REG_W-1:0]    reg_s;
        logic [mips_isa_pkg::REG_W-1:0]    reg_t;
        logic [mips_isa_pkg::IMM_W-1:0]    immediate;  // raw and not extended
    } i_fields_t;

    // jump class result
    typedef struct packed {
        mips_isa_pkg::inst_e               inst;
        logic [mips_isa_pkg::ADDR_W-1:0]   jump_address;
    } j_fields_t;

    // merged stage output of 72 bits
    typedef struct packed {
        mips_isa_pkg::inst_e               inst;
        mips_isa_pkg::inst_type_e          inst_type;
        logic [mips_isa_pkg::REG_W-1:0]    reg_s;
        logic [mips_isa_pkg::REG_W-1:0]    reg_t;
        logic [mips_isa_pkg::REG_W-1:0]    reg_d;
        logic [mips_isa_pkg::REG_W-1:0]    shift;
        logic [mips_isa_pkg::IMM_W-1:0]    immediate;
        logic [mips_isa_pkg::ADDR_W-1:0]   jump_address;
    } decoded_t;

endpackage

`default_nettype wire

// ==== id_r.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_r (
    input  logic [mips_isa_pkg::INST_W-1:0] inst_code,
    output decode_pkg::r_fields_t           fields
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    opcode_e op;
    funct_e  funct;
    inst_e   inst;

    assign op    = opcode_e'(inst_code[OP_LSB +: OP_W]);
    assign funct = funct_e'(inst_code[FUNCT_LSB +: FUNCT_W]);

    // only opcode zero belongs here and funct picks the op
    always_comb
    begin
        inst = INST_INVALID;
        if (op == OP_SPECIAL)
        begin
            case (funct)
                FN_ADD:  inst = INST_ADD;
                FN_ADDU: inst = INST_ADDU;
                FN_SUB:  inst = INST_SUB;
                FN_SUBU: inst = INST_SUBU;
                FN_AND:  inst = INST_AND;
                FN_OR:   inst = INST_OR;
                FN_XOR:  inst = INST_XOR;
                FN_NOR:  inst = INST_NOR;
                FN_SLT:  inst = INST_SLT;
                FN_SLTU: inst = INST_SLTU;
                FN_SLL:  inst = INST_SLL;
                FN_SRL:  inst = INST_SRL;
                FN_SRA:  inst = INST_SRA;
                FN_SLLV: inst = INST_SLLV;
                FN_SRLV: inst = INST_SRLV;
                FN_SRAV: inst = INST_SRAV;
                FN_JR:   inst = INST_JR;
                default: inst = INST_INVALID;  // unsupported funct
            endcase
        end
    end

    always_comb
    begin
        fields.inst  = inst;
        fields.reg_s = inst_code[RS_LSB +: REG_W];
        fields.reg_t = inst_code[RT_LSB +: REG_W];
        fields.reg_d = inst_code[RD_LSB +: REG_W];
        case (inst)
            INST_SLL, INST_SRL, INST_SRA:
                fields.shift = inst_code[SHAMT_LSB +: REG_W];
            default:
                fields.shift = '0;  // variable shifts take rs instead
        endcase
    end

    // a funct match must never leak through from another opcode
    always_comb
    begin
        if (fields.inst != INST_INVALID)
        begin
            assert (inst_code[OP_LSB +: OP_W] == OP_SPECIAL)
                else $error("id_r: recognized word with nonzero opcode");
        end
    end

endmodule

`default_nettype wire

// ==== id_i.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_i (
    input  logic [mips_isa_pkg::INST_W-1:0] inst_code,
    output decode_pkg::i_fields_t           fields
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    opcode_e op;
    inst_e   inst;

    assign op = opcode_e'(inst_code[OP_LSB +: OP_W]);

    always_comb
    begin
        case (op)
            // arithmetic and logic with immediate
            OP_ADDI:  inst = INST_ADDI;
            OP_ADDIU: inst = INST_ADDIU;
            OP_SLTI:  inst = INST_SLTI;
            OP_SLTIU: inst = INST_SLTIU;
            OP_ANDI:  inst = INST_ANDI;
            OP_ORI:   inst = INST_ORI;
            OP_XORI:  inst = INST_XORI;
            OP_LUI:   inst = INST_LUI;
            // branches with offset in immediate
            OP_BEQ:   inst = INST_BEQ;
            OP_BNE:   inst = INST_BNE;
            // memory
            OP_LW:    inst = INST_LW;
            OP_SW:    inst = INST_SW;
            default:  inst = INST_INVALID;
        endcase
    end

    always_comb
    begin
        fields.inst      = inst;
        fields.reg_t     = inst_code[RT_LSB +: REG_W];
        fields.immediate = inst_code[IMM_LSB +: IMM_W];

        // lui has no source so rs bits are don't care in the encoding
        if (inst == INST_LUI)
        begin
            fields.reg_s = '0;
        end
        else
        begin
            fields.reg_s = inst_code[RS_LSB +: REG_W];
        end
    end

endmodule

`default_nettype wire

// ==== id_j.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_j (
    input  logic [mips_isa_pkg::INST_W-1:0] inst_code,
    output decode_pkg::j_fields_t           fields
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    opcode_e op;

    assign op = opcode_e'(inst_code[OP_LSB +: OP_W]);

    always_comb
    begin
        case (op)
            OP_J:    fields.inst = INST_J;
            OP_JAL:  fields.inst = INST_JAL;  // link reg is implicit
            default: fields.inst = INST_INVALID;
        endcase
        // word index with pc upper bits added in fetch
        fields.jump_address = inst_code[ADDR_LSB +: ADDR_W];
    end

endmodule

`default_nettype wire

// ==== id.sv ====
`timescale 1ns/1ps
`default_nettype none

module id (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [mips_isa_pkg::INST_W-1:0] inst_code,
    output logic                            out_valid,
    output decode_pkg::decoded_t            out_dec,
    input  logic                            out_ready
);
    import mips_isa_pkg::*;
    import decode_pkg::*;

    r_fields_t  r_fields;
    i_fields_t  i_fields;
    j_fields_t  j_fields;
    inst_type_e inst_type;
    decoded_t   dec_next;
    logic       accept;

    id_r id_r_decode (
        .inst_code (inst_code),
        .fields    (r_fields)
    );

    id_i id_i_decode (
        .inst_code (inst_code),
        .fields    (i_fields)
    );

    id_j id_j_decode (
        .inst_code (inst_code),
        .fields    (j_fields)
    );

    // class priority is I then R then J
    always_comb
    begin
        if (i_fields.inst != INST_INVALID)
            inst_type = INST_TYPE_I;
        else if (r_fields.inst != INST_INVALID)
            inst_type = INST_TYPE_R;
        else if (j_fields.inst != INST_INVALID)
            inst_type = INST_TYPE_J;
        else
            inst_type = INST_TYPE_INVALID;
    end

    // take the chosen class and zero whatever it doesn't use
    always_comb
    begin
        dec_next           = '0;
        dec_next.inst_type = inst_type;
        case (inst_type)
            INST_TYPE_R:
            begin
                dec_next.inst  = r_fields.inst;
                dec_next.reg_s = r_fields.reg_s;
                dec_next.reg_t = r_fields.reg_t;
                dec_next.reg_d = r_fields.reg_d;
                dec_next.shift = r_fields.shift;
            end
            INST_TYPE_I:
            begin
                dec_next.inst      = i_fields.inst;
                dec_next.reg_s     = i_fields.reg_s;
                dec_next.reg_t     = i_fields.reg_t;
                dec_next.immediate = i_fields.immediate;
            end
            INST_TYPE_J:
            begin
                dec_next.inst         = j_fields.inst;
                dec_next.jump_address = j_fields.jump_address;
            end
            default:
                dec_next.inst = INST_INVALID;  // all operands stay zero
        endcase
    end

    // one-entry stage that can refill while draining
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            out_dec <= dec_next;
    end

    // stalled output must not move
    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_dec));

    a_type_matches_inst: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> ((out_dec.inst_type == INST_TYPE_INVALID)
                       == (out_dec.inst == INST_INVALID)));

    // encodings of the three classes are disjoint
    a_one_class: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> $onehot0({r_fields.inst != INST_INVALID,
                               i_fields.inst != INST_INVALID,
                               j_fields.inst != INST_INVALID}));

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // low from 1 ns to 20 ns across the first two rising edges
    initial
    begin
        arst_n = 1'b1;
        #1 arst_n = 1'b0;
        #19 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_id.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_id;
    import mips_isa_pkg::*;
    import decode_pkg::*;

    localparam int MODE_R      = 0;
    localparam int MODE_I      = 1;
    localparam int MODE_J      = 2;
    localparam int MODE_RAND   = 3;
    localparam int MODE_MIX    = 4;  // any of the four above picked per word
    localparam int TOTAL_WORDS = 900;
    localparam int CYCLE_LIMIT = 4 * TOTAL_WORDS + 100;

    // funct and opcode values taken from the MIPS encoding tables
    localparam logic [5:0] R_FN [17] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25,
        6'h26, 6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08};
    localparam logic [7:0] R_IN [17] = '{INST_ADD, INST_ADDU, INST_SUB, INST_SUBU,
        INST_AND, INST_OR, INST_XOR, INST_NOR, INST_SLT, INST_SLTU, INST_SLL, INST_SRL,
        INST_SRA, INST_SLLV, INST_SRLV, INST_SRAV, INST_JR};
    localparam logic [5:0] I_OP [12] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d,
        6'h0e, 6'h0f, 6'h04, 6'h05, 6'h23, 6'h2b};
    localparam logic [7:0] I_IN [12] = '{INST_ADDI, INST_ADDIU, INST_SLTI, INST_SLTIU,
        INST_ANDI, INST_ORI, INST_XORI, INST_LUI, INST_BEQ, INST_BNE, INST_LW, INST_SW};

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] inst_code;
    logic        out_valid;
    decoded_t    out_dec;
    logic        out_ready;

    logic [31:0] lfsr;
    decoded_t    exp_q [$];  // scoreboard in acceptance order
    int          check_count;
    int          err_count;
    int          cycles;

    tb_clock clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    id id_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .inst_code (inst_code),
        .out_valid (out_valid),
        .out_dec   (out_dec),
        .out_ready (out_ready)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // one step per bit
        end
    endtask

    task automatic make_word(input int mode, output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] f;
        int          m;
        int          idx;
        m = mode;
        if (m == MODE_MIX)
        begin
            take_bits(2, r);
            m = int'(r[1:0]);
        end
        take_bits(26, f);  // operand fields
        case (m)
            MODE_R:
            begin
                take_bits(5, r);
                idx = int'(r % 32'd17);
                w   = {6'h00, f[19:0], R_FN[idx]};
            end
            MODE_I:
            begin
                take_bits(4, r);
                idx = int'(r % 32'd12);
                w   = {I_OP[idx], f[25:0]};
            end
            MODE_J:
            begin
                take_bits(1, r);
                w = {5'b00001, r[0], f[25:0]};  // opcode 2 or 3
            end
            default:
                take_bits(32, w);
        endcase
    endtask

    // reference decode straight from the ISA tables
    function automatic decoded_t model_decode(input logic [31:0] w);
        decoded_t d;
        int       k;
        d = '0;
        for (k = 0; k < 12; k++)
        begin
            if (w[31:26] == I_OP[k])
            begin
                d.inst      = inst_e'(I_IN[k]);
                d.inst_type = INST_TYPE_I;
                d.reg_s     = (w[31:26] == 6'h0f) ? 5'd0 : w[25:21];  // lui
                d.reg_t     = w[20:16];
                d.immediate = w[15:0];
            end
        end
        if (w[31:26] == 6'h00)
        begin
            for (k = 0; k < 17; k++)
            begin
                if (w[5:0] == R_FN[k])
                begin
                    d.inst      = inst_e'(R_IN[k]);
                    d.inst_type = INST_TYPE_R;
                    d.reg_s     = w[25:21];
                    d.reg_t     = w[20:16];
                    d.reg_d     = w[15:11];
                    // funct 0 2 3 are the constant shifts and 1 is not in the table
                    if (w[5:0] <= 6'h03)
                        d.shift = w[10:6];
                end
            end
        end
        if (w[31:27] == 5'b00001)
        begin
            d.inst         = w[26] ? INST_JAL : INST_J;
            d.inst_type    = INST_TYPE_J;
            d.jump_address = w[25:0];
        end
        return d;
    endfunction

    task automatic check_idle(input string when);
        check_count++;
        assert (!out_valid && in_ready)
        else
        begin
            $display("[ERROR] reset: %s expected out_valid=0 in_ready=1, actual %b %b",
                     when, out_valid, in_ready);
            err_count++;
        end
    endtask

    task automatic compare_output(input string name);
        decoded_t exp;
        check_count++;
        assert (exp_q.size() != 0)
        else
        begin
            $display("%s: output transfer with no word outstanding", name);
            err_count++;
        end
        if (exp_q.size() != 0)
        begin
            exp = exp_q.pop_front();
            check_count++;
            assert (out_dec == exp)
            else
            begin
                $display("[ERROR] %s: expected %h actual %h", name, exp, out_dec);
                err_count++;
            end
        end
    endtask

    task automatic report_test(input string name, input string what, input int errs_before);
        string verdict;
        if (err_count == errs_before)
            verdict = "ok";
        else
            verdict = "FAILED";
        $display("test %-12s %-12s %s", name, what, verdict);
    endtask

    task automatic run_test(input string name, input int mode, input int count,
                            input logic half_ready);
        logic [31:0] r;
        logic [31:0] w;
        logic        took;
        logic        exp_full;
        int          sent;
        int          errs_before;
        sent        = 0;
        took        = 1'b0;
        errs_before = err_count;
        while (sent < count || exp_q.size() != 0)
        begin
            @(negedge clk);
            if (took)
                in_valid = 1'b0;
            // a word not yet taken stays on the bus
            if (!in_valid && sent < count)
            begin
                take_bits(2, r);
                if (r[1:0] != 2'b00)
                begin
                    make_word(mode, w);
                    inst_code = w;
                    in_valid  = 1'b1;
                end
            end
            take_bits(2, r);
            out_ready = half_ready ? r[0] : (r[1:0] != 2'b00);
            #1;
            exp_full = (exp_q.size() != 0);  // one word held in the output register
            check_count++;
            assert (out_valid == exp_full && in_ready == (!exp_full || out_ready))
            else
            begin
                $display("[ERROR] %s: expected out_valid=%b in_ready=%b actual %b %b",
                         name, exp_full, !exp_full || out_ready, out_valid, in_ready);
                err_count++;
            end
            if (out_valid && out_ready)
                compare_output(name);
            took = in_valid && in_ready;  // transfer at the coming edge
            if (took)
            begin
                exp_q.push_back(model_decode(inst_code));
                sent++;
            end
        end
        report_test(name, $sformatf("%0d words", count), errs_before);
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        int errs_before;
        in_valid    = 1'b0;
        inst_code   = '0;
        out_ready   = 1'b0;
        lfsr        = 32'h1110;
        check_count = 0;
        err_count   = 0;

        errs_before = err_count;
        @(negedge clk);
        #1;
        check_idle("during reset");
        wait (arst_n);
        @(negedge clk);
        #1;
        check_idle("after reset");
        report_test("reset", "idle state", errs_before);

        run_test("r_type", MODE_R, 200, 1'b0);
        run_test("i_type", MODE_I, 200, 1'b0);
        run_test("j_type", MODE_J, 100, 1'b0);
        run_test("invalid", MODE_RAND, 200, 1'b0);
        run_test("backpressure", MODE_MIX, 200, 1'b1);

        @(negedge clk);
        #1;
        check_count++;
        assert (!out_valid && exp_q.size() == 0)
        else
        begin
            $display("stage not drained, %0d words still expected", exp_q.size());
            err_count++;
        end

        $display("checks: %0d passed, %0d failed", check_count - err_count, err_count);
        if (err_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
mips_isa_pkg.sv
decode_pkg.sv
id_r.sv
id_i.sv
id_j.sv
id.sv
tb_clock.sv
tb_id.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_id
	@out="$$(./obj_dir/Vtb_id)"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
